//--- doc5503_tests.txt
# op name arg_a arg_b arg_c, arguments in hex
# F fill base count byte, W write addr data, R read addr expected, N wait frames, M mix expected
R reset_osc_en e1 02 0
M reset_mix 0000 0 0
W rw_fl 05 a7 0
R rw_fl 05 a7 0
W rw_fh 25 3c 0
R rw_fh 25 3c 0
W rw_vol 49 e8 0
R rw_vol 49 e8 0
W rw_wds 7f 5d 0
R rw_wds 7f 5d 0
W rw_wtp 8c 3c 0
R rw_wtp 8c 3c 0
W rw_ctrl b4 5b 0
R rw_ctrl b4 5b 0
W rw_rts c7 2d 0
R rw_rts c7 2d 0
R unmapped_e0 e0 00 0
R unmapped_f3 f3 00 0
F freq0_mem 1000 1 c0
F freq0_mem 3000 1 20
W freq0_osc_en e1 04 0
R freq0_osc_en e1 04 0
W freq0_setup 00 00 0
W freq0_setup 20 00 0
W freq0_setup 40 fc 0
W freq0_setup 80 10 0
W freq0_setup c0 00 0
W freq0_setup a0 00 0
W freq0_setup 01 00 0
W freq0_setup 21 00 0
W freq0_setup 41 83 0
W freq0_setup 81 30 0
W freq0_setup c1 00 0
W freq0_setup a1 00 0
N freq0_run 4 0 0
M freq0_mix 03c0 0 0
W table_addr_setup c1 12 0
W table_addr_setup 81 2b 0
W table_addr_setup 21 f0 0
N table_addr_run c 0 0
W one_shot_setup a1 02 0
N one_shot_run c 0 0
R one_shot_halt a1 03 0
R one_shot_wds 61 80 0
M one_shot_mix 0fc0 0 0
F zero_table_mem 5000 100 00
W zero_table_setup 21 00 0
W zero_table_setup c1 00 0
W zero_table_setup 81 30 0
W zero_table_setup a1 00 0
W zero_table_setup 80 50 0
N zero_table_run 6 0 0
R zero_table_halt a0 01 0
R zero_table_wds 60 80 0
M zero_table_mix f400 0 0

//--- flist.f
doc_regs_pkg.sv
doc_osc_pkg.sv
doc_register_file.sv
doc_cycle_timer.sv
doc_osc_engine.sv
doc_mixer.sv
doc5503.sv
tb_doc5503.sv

//--- run.sh
#!/bin/sh
# compile and run the DOC5503 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_doc5503 -f flist.f --Mdir obj_dir -o sim_doc5503 > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_doc5503 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb_doc5503.sv
`timescale 1ns/1ps
// DOC5503 testbench
module tb_doc5503;
    import doc_regs_pkg::*;
    import doc_osc_pkg::*;

    // frame with all 32 oscillators enabled, four clocks per clock enable
    localparam int LONGEST_FRAME = ((OSC_COUNT_MAX - 1) * SLOT_STEPS + LAST_SLOT_STEPS) * 4;

    // the three hex arguments of one command line
    typedef struct packed {
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] arg_c;
    } cmd_args_t;

    logic        clk_i = 1'b0;
    logic        reset_n_i;
    logic        clk_en_i = 1'b0;
    logic        cs_n_i;
    logic        we_n_i;
    logic [7:0]  addr_i;
    logic [7:0]  data_i;
    logic [7:0]  data_o;
    logic [15:0] wave_address_o;
    logic        wave_rd_o;
    logic        wave_data_ready_i = 1'b0;
    logic [7:0]  wave_data_i = 8'h00;
    sample_t     mono_mix_o;

    logic [7:0]  wave_mem [65536];
    string       op_q [$];
    string       name_q [$];
    cmd_args_t   args_q [$];
    string       test_name = "startup";
    logic [7:0]  osc_en_shadow = OSC_EN_RESET;
    longint      cycle_count = 0;
    // generous until the test file has been loaded
    longint      cycle_limit = 100000;
    logic [1:0]  en_div = 2'd0;
    int          rd_delay = 0;
    logic [15:0] rd_addr;

    // table registers as the DUT saw them one clock earlier
    logic [7:0]  wtp_shadow [OSC_COUNT_MAX];
    logic [7:0]  rts_shadow [OSC_COUNT_MAX];
    logic        wtp_known [OSC_COUNT_MAX] = '{default: 1'b0};
    logic        rts_known [OSC_COUNT_MAX] = '{default: 1'b0};
    logic        wr_pend = 1'b0;
    logic [7:0]  wr_pend_addr;
    logic [7:0]  wr_pend_data;

    doc5503 #(
        .MIX_SUM_WIDTH (16)
    ) dut_i (.*);

    always #10 clk_i = ~clk_i;

    // one clock enable on every fourth clock
    always @(posedge clk_i) begin
        en_div   <= en_div + 2'd1;
        clk_en_i <= en_div == 2'd3;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_run($sformatf("run exceeded the cycle limit of %0d in test %s",
                               cycle_limit, test_name));
        end
    end

    // wave memory answers each read two clocks after it is seen
    always @(posedge clk_i) begin
        wave_data_ready_i <= 1'b0;
        if (rd_delay == 1) begin
            wave_data_ready_i <= 1'b1;
            wave_data_i       <= wave_mem[rd_addr];
        end
        if (rd_delay != 0) begin
            rd_delay = rd_delay - 1;
        end
        if (reset_n_i && wave_rd_o) begin
            rd_addr  = wave_address_o;
            rd_delay = 2;
        end
    end

    // the page bits above the table size must match some configured table
    function automatic logic in_known_table(input logic [15:0] addr);
        logic [7:0] mask;
        for (int i = 0; i < OSC_COUNT_MAX; i++) begin
            mask = 8'hFF << rts_shadow[i][5:3];
            if (wtp_known[i] && rts_known[i]
                && (addr[15:8] & mask) == (wtp_shadow[i] & mask)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // every fetch is checked against the tables before the latest host write lands
    always @(posedge clk_i) begin
        if (reset_n_i && wave_rd_o) begin
            assert (in_known_table(wave_address_o)) else begin
                stop_run($sformatf(
                    "FAIL %s: expected an address in a configured table, actual %04h",
                    test_name, wave_address_o));
            end
        end
        if (wr_pend && wr_pend_addr[7:5] == REG_GRP_WTP) begin
            wtp_shadow[wr_pend_addr[4:0]] = wr_pend_data;
            wtp_known[wr_pend_addr[4:0]]  = 1'b1;
        end
        if (wr_pend && wr_pend_addr[7:5] == REG_GRP_RTS) begin
            rts_shadow[wr_pend_addr[4:0]] = wr_pend_data;
            rts_known[wr_pend_addr[4:0]]  = 1'b1;
        end
        wr_pend      = !cs_n_i && !we_n_i;
        wr_pend_addr = addr_i;
        wr_pend_data = data_i;
    end

    // slots of 8 steps and a last slot of 24, four clocks per step
    function automatic int frame_clocks();
        int slots;
        slots = osc_en_shadow[6:1];
        if (slots == 0) begin
            slots = 1;
        end else if (slots > OSC_COUNT_MAX) begin
            slots = OSC_COUNT_MAX;
        end
        return ((slots - 1) * SLOT_STEPS + LAST_SLOT_STEPS) * 4;
    endfunction

    task automatic fill_wave_memory(input logic [15:0] base, input int count,
                                    input logic [7:0] value);
        for (int i = 0; i < count; i++) begin
            wave_mem[16'(base + i)] = value;
        end
    endtask

    task automatic write_register(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk_i);
        cs_n_i <= 1'b0;
        we_n_i <= 1'b0;
        addr_i <= addr;
        data_i <= data;
        @(posedge clk_i);
        cs_n_i <= 1'b1;
        we_n_i <= 1'b1;
        if (addr == REG_ADDR_OSC_EN) begin
            osc_en_shadow = data;
        end
    endtask

    // data_o is combinational, so it is sampled half a clock after the address
    task automatic read_register(input logic [7:0] addr, input logic [7:0] expected);
        @(posedge clk_i);
        cs_n_i <= 1'b0;
        we_n_i <= 1'b1;
        addr_i <= addr;
        @(negedge clk_i);
        assert (data_o === expected) else begin
            stop_run($sformatf("FAIL %s: register %02h expected %02h actual %02h",
                               test_name, addr, expected, data_o));
        end
        @(posedge clk_i);
        cs_n_i <= 1'b1;
    endtask

    task automatic wait_frames(input int frames);
        repeat (frames * frame_clocks()) @(posedge clk_i);
    endtask

    task automatic check_mix(input logic [15:0] expected);
        @(negedge clk_i);
        assert (mono_mix_o === sample_t'(expected)) else begin
            stop_run($sformatf("FAIL %s: mono mix expected %04h actual %04h",
                               test_name, expected, mono_mix_o));
        end
    endtask

    initial begin
        int          fd;
        int          code;
        longint      frames;
        string       line;
        string       op;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        cmd_args_t   args;

        reset_n_i = 1'b0;
        cs_n_i    = 1'b1;
        we_n_i    = 1'b1;
        addr_i    = 8'h00;
        data_i    = 8'h00;
        frames    = 0;

        // background bytes run from 01 to ff and change with every address bit
        for (int i = 0; i < 65536; i++) begin
            wave_mem[i] = 8'((i % 255) + 1);
        end

        fd = $fopen("doc5503_tests.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the test file doc5503_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            code = $sscanf(line, "%s %s %h %h %h", op, name, a, b, c);
            if (code != 5) begin
                stop_run($sformatf("malformed line in the test file: %s", line));
            end
            args = '{arg_a: a, arg_b: b, arg_c: c};
            op_q.push_back(op);
            name_q.push_back(name);
            args_q.push_back(args);
            if (op == "N") begin
                frames += a;
            end
        end
        $fclose(fd);
        cycle_limit = frames * LONGEST_FRAME + 64 * op_q.size() + 2000;

        repeat (10) @(posedge clk_i);
        reset_n_i <= 1'b1;
        // the power-up sweep owns the control and sample entries for 32 clocks
        repeat (40) @(posedge clk_i);

        for (int k = 0; k < op_q.size(); k++) begin
            test_name = name_q[k];
            args      = args_q[k];
            if (op_q[k] == "F") begin
                fill_wave_memory(args.arg_a[15:0], args.arg_b, args.arg_c[7:0]);
            end else if (op_q[k] == "W") begin
                write_register(args.arg_a[7:0], args.arg_b[7:0]);
            end else if (op_q[k] == "R") begin
                read_register(args.arg_a[7:0], args.arg_b[7:0]);
            end else if (op_q[k] == "N") begin
                wait_frames(args.arg_a);
            end else if (op_q[k] == "M") begin
                check_mix(args.arg_a[15:0]);
            end else begin
                stop_run($sformatf("unknown command %s in test %s", op_q[k], test_name));
            end
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- doc5503.sv
`timescale 1ns/1ps
// DOC5503 wavetable engine
module doc5503 #(
    parameter int MIX_SUM_WIDTH = 16
) (
    input  logic                 clk_i,
    input  logic                 reset_n_i,
    input  logic                 clk_en_i,
    input  logic                 cs_n_i,
    input  logic                 we_n_i,
    input  logic [7:0]           addr_i,
    input  logic [7:0]           data_i,
    output logic [7:0]           data_o,
    output logic [15:0]          wave_address_o,
    output logic                 wave_rd_o,
    input  logic                 wave_data_ready_i,
    input  logic [7:0]           wave_data_i,
    output doc_osc_pkg::sample_t mono_mix_o
);
    import doc_osc_pkg::*;

    logic       ready_w;
    logic       frame_end_w;
    logic [4:0] step_w;
    osc_num_t   init_osc_w;
    osc_num_t   cur_osc_w;
    osc_num_t   osc_count_w;
    osc_regs_t  regs_w;
    osc_wb_t    wb_w;
    sample_wr_t sample_w;

    doc_register_file regs_i (
        .clk_i, .reset_n_i, .cs_n_i, .we_n_i, .addr_i, .data_i, .data_o,
        .ready_i     (ready_w),
        .init_osc_i  (init_osc_w),
        .cur_osc_i   (cur_osc_w),
        .wb_i        (wb_w),
        .regs_o      (regs_w),
        .osc_count_o (osc_count_w)
    );

    doc_cycle_timer timer_i (
        .clk_i, .reset_n_i, .clk_en_i,
        .osc_count_i (osc_count_w),
        .ready_o     (ready_w),
        .init_osc_o  (init_osc_w),
        .cur_osc_o   (cur_osc_w),
        .step_o      (step_w),
        .frame_end_o (frame_end_w)
    );

    doc_osc_engine engine_i (
        .clk_i, .reset_n_i, .clk_en_i,
        .step_i    (step_w),
        .cur_osc_i (cur_osc_w),
        .regs_i    (regs_w),
        .wb_o      (wb_w),
        .wave_address_o, .wave_rd_o, .wave_data_ready_i, .wave_data_i,
        .sample_o  (sample_w)
    );

    doc_mixer #(
        .MIX_SUM_WIDTH (MIX_SUM_WIDTH)
    ) mixer_i (
        .clk_i, .reset_n_i,
        .frame_end_i (frame_end_w),
        .osc_count_i (osc_count_w),
        .sample_i    (sample_w),
        .mono_mix_o
    );

endmodule

//--- doc_mixer.sv
`timescale 1ns/1ps
// DOC mono mixer
module doc_mixer #(
    parameter int MIX_SUM_WIDTH = 16
) (
    input  logic                    clk_i,
    input  logic                    reset_n_i,
    input  logic                    frame_end_i,
    input  doc_osc_pkg::osc_num_t   osc_count_i,
    input  doc_osc_pkg::sample_wr_t sample_i,
    output doc_osc_pkg::sample_t    mono_mix_o
);
    import doc_osc_pkg::*;

    sample_t  store_r [OSC_COUNT_MAX];
    logic     busy_r;
    logic     done_r;
    osc_num_t idx_r;
    osc_num_t last_r;
    logic signed [MIX_SUM_WIDTH-1:0] sum_r;

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            for (int i = 0; i < OSC_COUNT_MAX; i++) begin
                store_r[i] <= '0;
            end
            busy_r     <= 1'b0;
            done_r     <= 1'b0;
            idx_r      <= '0;
            mono_mix_o <= '0;
        end else begin
            // latest sample per oscillator, updated while a sum runs
            if (sample_i.valid) begin
                store_r[sample_i.osc] <= sample_i.sample;
            end
            done_r <= 1'b0;
            if (frame_end_i) begin
                // the count is frozen for the whole walk
                busy_r <= 1'b1;
                idx_r  <= '0;
                last_r <= osc_count_i;
                sum_r  <= '0;
            end else if (busy_r) begin
                // one entry per clock, sign extended and wrapping at the sum width
                sum_r <= sum_r + MIX_SUM_WIDTH'(store_r[idx_r]);
                idx_r <= idx_r + 1'b1;
                if (idx_r == last_r) begin
                    busy_r <= 1'b0;
                    done_r <= 1'b1;
                end
            end
            if (done_r) begin
                mono_mix_o <= sum_r[MIX_SUM_WIDTH-1 -: 16];
            end
        end
    end

    // a frame is far longer than the walk over 32 entries
    a_no_overlap: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        frame_end_i |-> !busy_r && !done_r);

endmodule

//--- doc_osc_engine.sv
`timescale 1ns/1ps
// DOC oscillator engine
module doc_osc_engine (
    input  logic                   clk_i,
    input  logic                   reset_n_i,
    input  logic                   clk_en_i,
    input  logic [4:0]             step_i,
    input  doc_osc_pkg::osc_num_t  cur_osc_i,
    input  doc_osc_pkg::osc_regs_t regs_i,
    output doc_osc_pkg::osc_wb_t   wb_o,
    output logic [15:0]            wave_address_o,
    output logic                   wave_rd_o,
    input  logic                   wave_data_ready_i,
    input  logic [7:0]             wave_data_i,
    output doc_osc_pkg::sample_wr_t sample_o
);
    import doc_regs_pkg::*;
    import doc_osc_pkg::*;

    logic [ACC_WIDTH-1:0] acc_r [OSC_COUNT_MAX];
    logic [15:0] wave_addr_r;
    // slot FSM state, set at step 0 and dropped once the slot is finished
    logic        live_r;
    logic        halt_req_r;
    osc_num_t    fetch_osc_r;
    logic        fetch_busy_r;
    logic [7:0]  data_r;
    logic        data_pend_r;

    logic        one_shot_w;
    logic [4:0]  shift_w;
    logic        overflow_w;
    logic        zero_byte_w;
    logic [15:0] tbl_mask_w;
    logic [7:0]  page_w;
    logic        halt_now_w;
    sample_t     scaled_w;

    assign one_shot_w = regs_i.ctrl.mode == MODE_ONE_SHOT;
    // barrel shift picks a 16 bit window out of the 24 bit accumulator
    assign shift_w = 5'd9 + {2'b00, regs_i.rts.resolution} - {2'b00, regs_i.rts.table_size};
    // the bit just above the table marks a wrap past its end
    assign overflow_w  = wave_addr_r[{1'b1, regs_i.rts.table_size}];
    assign zero_byte_w = regs_i.wds == 8'h00;
    assign tbl_mask_w  = (16'h0100 << regs_i.rts.table_size) - 16'd1;
    assign page_w      = regs_i.wtp & (8'hFF << regs_i.rts.table_size);
    assign halt_now_w  = clk_en_i && step_i == 5'd4 && live_r && halt_req_r;

    // sample byte re-centred on zero, times the top six volume bits
    assign scaled_w = $signed(regs_i.wds ^ WDS_SILENCE) * $signed({2'b00, regs_i.vol[7:2]});

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            for (int i = 0; i < OSC_COUNT_MAX; i++) begin
                acc_r[i] <= '0;
            end
            live_r       <= 1'b0;
            halt_req_r   <= 1'b0;
            fetch_busy_r <= 1'b0;
            data_pend_r  <= 1'b0;
            wave_rd_o    <= 1'b0;
            wb_o         <= '0;
            sample_o     <= '0;
        end else begin
            wave_rd_o      <= 1'b0;
            wb_o           <= '0;
            sample_o.valid <= 1'b0;

            // fetched byte goes back to its oscillator, a halt in the same clock goes first
            if (data_pend_r && !halt_now_w) begin
                wb_o        <= '{halt: 1'b0, wds_wr: 1'b1, osc: fetch_osc_r, wds: data_r};
                data_pend_r <= 1'b0;
            end
            if (wave_data_ready_i) begin
                data_r       <= wave_data_i;
                data_pend_r  <= 1'b1;
                fetch_busy_r <= 1'b0;
            end

            if (clk_en_i) begin
                case (step_i)
                    5'd0: begin
                        live_r     <= 1'b1;
                        halt_req_r <= 1'b0;
                    end
                    5'd1: if (live_r) begin
                        if (regs_i.ctrl.halt) begin
                            // a halted one-shot sits at the start of its table
                            if (one_shot_w) begin
                                acc_r[cur_osc_i] <= '0;
                            end
                            sample_o <= '{valid: 1'b1, osc: cur_osc_i, sample: '0};
                            live_r   <= 1'b0;
                        end else begin
                            acc_r[cur_osc_i] <= acc_r[cur_osc_i] + ACC_WIDTH'(regs_i.freq);
                        end
                    end
                    5'd2: if (live_r) begin
                        wave_addr_r <= 16'(acc_r[cur_osc_i] >> shift_w);
                    end
                    5'd3: if (live_r) begin
                        if ((overflow_w && one_shot_w) || zero_byte_w) begin
                            halt_req_r <= 1'b1;
                        end else begin
                            // free run restarts at offset zero after a wrap
                            wave_address_o <= ((overflow_w ? 16'h0000 : wave_addr_r) & tbl_mask_w)
                                              | {page_w, 8'h00};
                            wave_rd_o    <= 1'b1;
                            fetch_osc_r  <= cur_osc_i;
                            fetch_busy_r <= 1'b1;
                        end
                        if (overflow_w || zero_byte_w) begin
                            acc_r[cur_osc_i] <= '0;
                        end
                    end
                    5'd4: if (live_r) begin
                        live_r <= 1'b0;
                        if (halt_req_r) begin
                            // silence the sample byte so a restart does not halt again
                            wb_o     <= '{halt: 1'b1, wds_wr: 1'b1, osc: cur_osc_i,
                                          wds: WDS_SILENCE};
                            sample_o <= '{valid: 1'b1, osc: cur_osc_i, sample: '0};
                        end else begin
                            sample_o <= '{valid: 1'b1, osc: cur_osc_i, sample: scaled_w};
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // wave memory answers once per fetch and before the following fetch
    a_ready_outstanding: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        wave_data_ready_i |-> fetch_busy_r);
    a_fetch_bound: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        wave_rd_o |-> !$past(fetch_busy_r) || $past(wave_data_ready_i));

endmodule

//--- doc_cycle_timer.sv
`timescale 1ns/1ps
// DOC slot and step timer
module doc_cycle_timer (
    input  logic                  clk_i,
    input  logic                  reset_n_i,
    input  logic                  clk_en_i,
    input  doc_osc_pkg::osc_num_t osc_count_i,
    output logic                  ready_o,
    output doc_osc_pkg::osc_num_t init_osc_o,
    output doc_osc_pkg::osc_num_t cur_osc_o,
    output logic [4:0]            step_o,
    output logic                  frame_end_o
);
    import doc_osc_pkg::*;

    logic last_slot_w;
    logic last_step_w;
    logic advance_w;

    // a lowered count ends the frame at the current slot
    assign last_slot_w = cur_osc_o >= osc_count_i;
    assign last_step_w = step_o == (last_slot_w ? 5'(LAST_SLOT_STEPS - 1) : 5'(SLOT_STEPS - 1));
    assign advance_w   = ready_o && clk_en_i;

    // one register entry per clock is initialised before the engine runs
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            ready_o    <= 1'b0;
            init_osc_o <= '0;
        end else if (!ready_o) begin
            init_osc_o <= init_osc_o + 1'b1;
            if (init_osc_o == osc_num_t'(OSC_COUNT_MAX - 1)) begin
                ready_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            step_o      <= '0;
            cur_osc_o   <= '0;
            frame_end_o <= 1'b0;
        end else begin
            frame_end_o <= advance_w && last_slot_w && last_step_w;
            if (advance_w) begin
                step_o <= last_step_w ? 5'd0 : step_o + 5'd1;
                if (last_step_w) begin
                    cur_osc_o <= last_slot_w ? '0 : cur_osc_o + 1'b1;
                end
            end
        end
    end

    // a slot beyond the enabled range only appears when the count has just been lowered
    a_slot_in_range: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        $rose(cur_osc_o > osc_count_i) |-> osc_count_i < $past(osc_count_i));

endmodule

//--- doc_register_file.sv
`timescale 1ns/1ps
// DOC oscillator register file
module doc_register_file (
    input  logic                   clk_i,
    input  logic                   reset_n_i,
    input  logic                   cs_n_i,
    input  logic                   we_n_i,
    input  logic [7:0]             addr_i,
    input  logic [7:0]             data_i,
    output logic [7:0]             data_o,
    input  logic                   ready_i,
    input  doc_osc_pkg::osc_num_t  init_osc_i,
    input  doc_osc_pkg::osc_num_t  cur_osc_i,
    input  doc_osc_pkg::osc_wb_t   wb_i,
    output doc_osc_pkg::osc_regs_t regs_o,
    output doc_osc_pkg::osc_num_t  osc_count_o
);
    import doc_regs_pkg::*;
    import doc_osc_pkg::*;

    logic [7:0] fl_r   [OSC_COUNT_MAX];
    logic [7:0] fh_r   [OSC_COUNT_MAX];
    logic [7:0] vol_r  [OSC_COUNT_MAX];
    logic [7:0] wds_r  [OSC_COUNT_MAX];
    logic [7:0] wtp_r  [OSC_COUNT_MAX];
    doc_ctrl_t  ctrl_r [OSC_COUNT_MAX];
    doc_rts_t   rts_r  [OSC_COUNT_MAX];
    logic [7:0] osc_en_r;

    logic       host_wr_w;
    osc_num_t   host_osc_w;
    doc_ctrl_t  wb_ctrl_w;
    logic [5:0] en_num_w;

    assign host_wr_w  = !cs_n_i && !we_n_i;
    assign host_osc_w = addr_i[4:0];

    // control entry of the write-back target with its halt bit forced on
    always_comb begin
        wb_ctrl_w      = ctrl_r[wb_i.osc];
        wb_ctrl_w.halt = 1'b1;
    end

    // later assignments win, so the order gives host < engine < init sweep
    always_ff @(posedge clk_i) begin
        if (host_wr_w) begin
            case (addr_i[7:5])
                REG_GRP_FL:   fl_r[host_osc_w]   <= data_i;
                REG_GRP_FH:   fh_r[host_osc_w]   <= data_i;
                REG_GRP_VOL:  vol_r[host_osc_w]  <= data_i;
                REG_GRP_WDS:  wds_r[host_osc_w]  <= data_i;
                REG_GRP_WTP:  wtp_r[host_osc_w]  <= data_i;
                REG_GRP_CTRL: ctrl_r[host_osc_w] <= doc_ctrl_t'(data_i);
                REG_GRP_RTS:  rts_r[host_osc_w]  <= doc_rts_t'(data_i);
                default: ;
            endcase
        end
        if (wb_i.wds_wr) begin
            wds_r[wb_i.osc] <= wb_i.wds;
        end
        if (wb_i.halt) begin
            ctrl_r[wb_i.osc] <= wb_ctrl_w;
        end
        // power-up sweep leaves every oscillator halted on a silent sample
        if (!ready_i) begin
            ctrl_r[init_osc_i] <= '{chan: 4'h0, irq_en: 1'b0, mode: MODE_FREE_RUN, halt: 1'b1};
            wds_r[init_osc_i]  <= WDS_SILENCE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            osc_en_r <= OSC_EN_RESET;
        end else if (host_wr_w && addr_i == REG_ADDR_OSC_EN) begin
            osc_en_r <= data_i;
        end
    end

    // E1 holds the count times two, zero still runs one oscillator
    assign en_num_w = osc_en_r[6:1];
    assign osc_count_o = (en_num_w == 6'd0) ? '0 :
                         (en_num_w > 6'(OSC_COUNT_MAX)) ? osc_num_t'(OSC_COUNT_MAX - 1) :
                         osc_num_t'(en_num_w - 6'd1);

    // host read path is purely combinational on the address
    always_comb begin
        case (addr_i[7:5])
            REG_GRP_FL:   data_o = fl_r[host_osc_w];
            REG_GRP_FH:   data_o = fh_r[host_osc_w];
            REG_GRP_VOL:  data_o = vol_r[host_osc_w];
            REG_GRP_WDS:  data_o = wds_r[host_osc_w];
            REG_GRP_WTP:  data_o = wtp_r[host_osc_w];
            REG_GRP_CTRL: data_o = ctrl_r[host_osc_w];
            REG_GRP_RTS:  data_o = rts_r[host_osc_w];
            default:      data_o = (addr_i == REG_ADDR_OSC_EN) ? osc_en_r : 8'h00;
        endcase
    end

    assign regs_o = '{
        freq: {fh_r[cur_osc_i], fl_r[cur_osc_i]},
        vol:  vol_r[cur_osc_i],
        wds:  wds_r[cur_osc_i],
        wtp:  wtp_r[cur_osc_i],
        ctrl: ctrl_r[cur_osc_i],
        rts:  rts_r[cur_osc_i]
    };

    // the engine only ever halts the oscillator whose slot is running
    a_halt_wb_cur: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        wb_i.halt |-> wb_i.osc == cur_osc_i);

endmodule

//--- doc_osc_pkg.sv
// DOC oscillator engine types
package doc_osc_pkg;

    localparam int OSC_COUNT_MAX = 32;

    typedef logic [$clog2(OSC_COUNT_MAX)-1:0] osc_num_t;

    // clock enable steps per slot, the last slot also covers memory refresh
    localparam int SLOT_STEPS      = 8;
    localparam int LAST_SLOT_STEPS = 24;

    localparam int ACC_WIDTH = 24;

    typedef logic signed [15:0] sample_t;

    // registers of the oscillator in the current slot
    typedef struct packed {
        logic [15:0]              freq;
        logic [7:0]               vol;
        logic [7:0]               wds;
        logic [7:0]               wtp;
        doc_regs_pkg::doc_ctrl_t  ctrl;
        doc_regs_pkg::doc_rts_t   rts;
    } osc_regs_t;

    // engine updates to the register file
    typedef struct packed {
        logic       halt;
        logic       wds_wr;
        osc_num_t   osc;
        logic [7:0] wds;
    } osc_wb_t;

    typedef struct packed {
        logic     valid;
        osc_num_t osc;
        sample_t  sample;
    } sample_wr_t;

endpackage

//--- doc_regs_pkg.sv
// DOC host register map
package doc_regs_pkg;

    // register groups are selected by addr[7:5], the oscillator by addr[4:0]
    localparam logic [2:0] REG_GRP_FL   = 3'd0;
    localparam logic [2:0] REG_GRP_FH   = 3'd1;
    localparam logic [2:0] REG_GRP_VOL  = 3'd2;
    localparam logic [2:0] REG_GRP_WDS  = 3'd3;
    localparam logic [2:0] REG_GRP_WTP  = 3'd4;
    localparam logic [2:0] REG_GRP_CTRL = 3'd5;
    localparam logic [2:0] REG_GRP_RTS  = 3'd6;

    // global enable register, holds twice the number of running oscillators
    localparam logic [7:0] REG_ADDR_OSC_EN = 8'hE1;
    localparam logic [7:0] OSC_EN_RESET    = 8'h02;

    // unsigned sample byte for zero level, 00 marks the end of a table
    localparam logic [7:0] WDS_SILENCE = 8'h80;

    // codes 10 (sync/AM) and 11 (swap) are reserved here and run as free run
    typedef enum logic [1:0] {
        MODE_FREE_RUN = 2'b00,
        MODE_ONE_SHOT = 2'b01
    } doc_mode_e;

    typedef struct packed {
        logic [3:0] chan;
        logic       irq_en;
        doc_mode_e  mode;
        logic       halt;
    } doc_ctrl_t;

    // table size gives 256 << n bytes, resolution picks the accumulator window
    typedef struct packed {
        logic [1:0] rsvd;
        logic [2:0] table_size;
        logic [2:0] resolution;
    } doc_rts_t;

endpackage
